/* include/dense_consts.svh */
`ifndef DENSE_CONSTS_SVH
`define DENSE_CONSTS_SVH

// ---------------------------------------------------------------------------
// layer shape
// ---------------------------------------------------------------------------

// samples per batch
`define DG_BATCH    4
// forward activations per sample
`define DG_HID_DIM  8
// backward errors per sample
`define DG_OUT_DIM  16
// gradient lanes per memory word
`define DG_LANES    8

// ---------------------------------------------------------------------------
// widths and memory geometry
// ---------------------------------------------------------------------------

`define DG_IN_W     8
`define DG_ACC_W    24
// hid_dim * out_dim / lanes
`define DG_WORDS    16
`define DG_ADDR_W   4

// pipeline latencies in cycles
`define DG_DOT_LAT  4
`define DG_RAM_LAT  1

`endif

/* source/fixed_pkg.sv */
`include "dense_consts.svh"

// fixed-point number formats shared by the gradient datapath
package fixed_pkg;

  // ---------------------------------------------------------------------------
  // scalar formats
  // ---------------------------------------------------------------------------

  // one activation or error sample
  typedef logic signed [`DG_IN_W-1:0] sample_t;

  // one gradient lane, wraps on overflow
  typedef logic signed [`DG_ACC_W-1:0] acc_t;

  // ---------------------------------------------------------------------------
  // memory word
  // ---------------------------------------------------------------------------

  // lane l holds output index blk * lanes + l
  typedef acc_t [`DG_LANES-1:0] grad_word_t;

endpackage

/* source/dense_shape_pkg.sv */
`include "dense_consts.svh"

// index, address and column types that follow the layer shape
package dense_shape_pkg;

  // ---------------------------------------------------------------------------
  // indices
  // ---------------------------------------------------------------------------

  // hidden index, selects one activation column
  typedef logic [$clog2(`DG_HID_DIM)-1:0] hid_idx_t;

  // output block, groups of lanes errors
  typedef logic [$clog2(`DG_OUT_DIM/`DG_LANES)-1:0] blk_idx_t;

  // gradient word address = hid * blocks + blk
  typedef logic [`DG_ADDR_W-1:0] grad_addr_t;

  // ---------------------------------------------------------------------------
  // batch columns
  // ---------------------------------------------------------------------------

  // element n is sample n of one hidden index
  typedef fixed_pkg::sample_t [`DG_BATCH-1:0] fwd_vec_t;

  // element n is sample n of one output index
  typedef fixed_pkg::sample_t [`DG_BATCH-1:0] bwd_vec_t;

endpackage

/* source/dense_dot.sv */
`timescale 1ns/100ps
`include "dense_consts.svh"

module dense_dot (
  input  logic                      clk,
  input  logic                      rst_n,
  input  dense_shape_pkg::fwd_vec_t fwd,
  input  dense_shape_pkg::bwd_vec_t bwd,
  output fixed_pkg::acc_t           q
);

  import fixed_pkg::*;

  localparam int PROD_W = 2 * `DG_IN_W;
  localparam int PAIRS  = `DG_BATCH / 2;
  localparam int PAIR_W = PROD_W + 1;
  localparam int SUM_W  = PROD_W + $clog2(`DG_BATCH);

  logic signed [PROD_W-1:0] prod_r [`DG_BATCH];
  logic signed [PAIR_W-1:0] pair_r [PAIRS];
  logic signed [SUM_W-1:0]  tree_sum;
  logic signed [SUM_W-1:0]  sum_r;

  // ---------------------------------------------------------------------------
  // stage 1 forms one product per sample
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int n = 0; n < `DG_BATCH; n++) begin
        prod_r[n] <= '0;
      end
    end else begin
      for (int n = 0; n < `DG_BATCH; n++) begin
        prod_r[n] <= fwd[n] * bwd[n];
      end
    end
  end

  // stage 2 adds neighbouring products in pairs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int p = 0; p < PAIRS; p++) begin
        pair_r[p] <= '0;
      end
    end else begin
      for (int p = 0; p < PAIRS; p++) begin
        pair_r[p] <= PAIR_W'(prod_r[2*p]) + PAIR_W'(prod_r[2*p+1]);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // stage 3 reduces the pair sums and stage 4 widens them to a lane
  // ---------------------------------------------------------------------------
  always_comb begin
    tree_sum = '0;
    for (int p = 0; p < PAIRS; p++) begin
      tree_sum = tree_sum + SUM_W'(pair_r[p]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_r <= '0;
      q     <= '0;
    end else begin
      sum_r <= tree_sum;
      // sign extension to the accumulator width
      q     <= acc_t'(sum_r);
    end
  end

endmodule

/* source/dense_weight_grad.sv */
`timescale 1ns/100ps
`include "dense_consts.svh"

module dense_weight_grad (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          run,
  input  fixed_pkg::sample_t [`DG_BATCH*`DG_HID_DIM-1:0] d_forward,
  input  fixed_pkg::sample_t [`DG_BATCH*`DG_OUT_DIM-1:0] d_backward,
  output dense_shape_pkg::grad_addr_t                   raddr,
  input  fixed_pkg::grad_word_t                         rdata,
  output dense_shape_pkg::grad_addr_t                   waddr,
  output fixed_pkg::grad_word_t                         wdata,
  output logic                                          we,
  output logic                                          done
);

  import fixed_pkg::*;
  import dense_shape_pkg::*;

  localparam int BLOCKS   = `DG_OUT_DIM / `DG_LANES;
  // read address to write address
  localparam int DELAY    = `DG_DOT_LAT + 1;
  // memory output to dot result
  localparam int RD_DELAY = `DG_DOT_LAT - `DG_RAM_LAT;

  // batch columns
  fwd_vec_t   fwd_col [`DG_HID_DIM];
  bwd_vec_t   bwd_blk [BLOCKS][`DG_LANES];

  // walk state
  grad_addr_t cnt;
  hid_idx_t   hid;
  blk_idx_t   blk;
  logic       walked;
  logic       step;

  // alignment pipes
  logic [DELAY-1:0] step_d;
  grad_addr_t       addr_d [DELAY];
  grad_word_t       rd_d   [RD_DELAY];
  acc_t             dot_q  [`DG_LANES];

  // ---------------------------------------------------------------------------
  // transpose sample-major inputs into per-index batch columns
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int h = 0; h < `DG_HID_DIM; h++) begin
      for (int n = 0; n < `DG_BATCH; n++) begin
        fwd_col[h][n] = d_forward[n*`DG_HID_DIM + h];
      end
    end
  end

  // error columns grouped by output block, one per lane
  always_comb begin
    for (int b = 0; b < BLOCKS; b++) begin
      for (int l = 0; l < `DG_LANES; l++) begin
        for (int n = 0; n < `DG_BATCH; n++) begin
          bwd_blk[b][l][n] = d_backward[n*`DG_OUT_DIM + b*`DG_LANES + l];
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // address walk, once per rise of run
  // ---------------------------------------------------------------------------
  assign step  = run && !walked;
  assign raddr = cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= '0;
      hid    <= '0;
      blk    <= '0;
      walked <= 1'b0;
    end else if (!run) begin
      cnt    <= '0;
      hid    <= '0;
      blk    <= '0;
      walked <= 1'b0;
    end else if (step) begin
      cnt <= cnt + 1'b1;
      if (blk == blk_idx_t'(BLOCKS - 1)) begin
        blk <= '0;
        hid <= hid + 1'b1;
      end else begin
        blk <= blk + 1'b1;
      end
      // last word issued, hold until run falls
      if (cnt == grad_addr_t'(`DG_WORDS - 1)) begin
        walked <= 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------------
  // delay lines
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_d <= '0;
    end else begin
      step_d <= {step_d[DELAY-2:0], step};
    end
  end

  always_ff @(posedge clk) begin
    addr_d[0] <= cnt;
    for (int i = 1; i < DELAY; i++) begin
      addr_d[i] <= addr_d[i-1];
    end
  end

  // stored word waits for the dot products
  always_ff @(posedge clk) begin
    rd_d[0] <= rdata;
    for (int i = 1; i < RD_DELAY; i++) begin
      rd_d[i] <= rd_d[i-1];
    end
  end

  // ---------------------------------------------------------------------------
  // one dot product per lane
  // ---------------------------------------------------------------------------
  for (genvar l = 0; l < `DG_LANES; l++) begin : g_lane
    dense_dot u_dot (
      .clk   (clk),
      .rst_n (rst_n),
      .fwd   (fwd_col[hid]),
      .bwd   (bwd_blk[blk][l]),
      .q     (dot_q[l])
    );
  end

  // read-modify-write sum, wraps at the lane width
  always_ff @(posedge clk) begin
    for (int l = 0; l < `DG_LANES; l++) begin
      wdata[l] <= rd_d[RD_DELAY-1][l] + dot_q[l];
    end
  end

  assign we    = step_d[DELAY-1];
  assign waddr = addr_d[DELAY-1];
  assign done  = we && (waddr == grad_addr_t'(`DG_WORDS - 1));

endmodule

/* source/grad_ram.sv */
`timescale 1ns/100ps
`include "dense_consts.svh"

module grad_ram (
  input  logic                        clk,
  input  dense_shape_pkg::grad_addr_t raddr,
  output fixed_pkg::grad_word_t       rdata,
  input  logic                        we,
  input  dense_shape_pkg::grad_addr_t waddr,
  input  fixed_pkg::grad_word_t       wdata
);

  import fixed_pkg::*;

  // ---------------------------------------------------------------------------
  // storage, one gradient word per address
  // ---------------------------------------------------------------------------
  grad_word_t mem [`DG_WORDS];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, returns the old word on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* source/dense_grad_top.sv */
`timescale 1ns/100ps
`include "dense_consts.svh"

module dense_grad_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          run,
  input  fixed_pkg::sample_t [`DG_BATCH*`DG_HID_DIM-1:0] d_forward,
  input  fixed_pkg::sample_t [`DG_BATCH*`DG_OUT_DIM-1:0] d_backward,
  output logic                                          done,
  input  dense_shape_pkg::grad_addr_t                   host_raddr,
  output fixed_pkg::grad_word_t                         host_rdata,
  input  logic                                          host_we,
  input  dense_shape_pkg::grad_addr_t                   host_waddr,
  input  fixed_pkg::grad_word_t                         host_wdata
);

  import fixed_pkg::*;
  import dense_shape_pkg::*;

  // engine side
  grad_addr_t eng_raddr;
  grad_addr_t eng_waddr;
  grad_word_t eng_wdata;
  logic       eng_we;

  // memory side
  grad_addr_t ram_raddr;
  grad_addr_t ram_waddr;
  grad_word_t ram_wdata;
  grad_word_t ram_rdata;
  logic       ram_we;

  // ---------------------------------------------------------------------------
  // gradient engine
  // ---------------------------------------------------------------------------
  dense_weight_grad u_grad (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .d_forward  (d_forward),
    .d_backward (d_backward),
    .raddr      (eng_raddr),
    .rdata      (ram_rdata),
    .waddr      (eng_waddr),
    .wdata      (eng_wdata),
    .we         (eng_we),
    .done       (done)
  );

  // ---------------------------------------------------------------------------
  // memory ports, host owns them while run is low
  // ---------------------------------------------------------------------------
  assign ram_raddr  = run ? eng_raddr : host_raddr;
  assign ram_waddr  = run ? eng_waddr : host_waddr;
  assign ram_wdata  = run ? eng_wdata : host_wdata;
  assign ram_we     = run ? eng_we    : host_we;
  assign host_rdata = ram_rdata;

  grad_ram u_ram (
    .clk   (clk),
    .raddr (ram_raddr),
    .rdata (ram_rdata),
    .we    (ram_we),
    .waddr (ram_waddr),
    .wdata (ram_wdata)
  );

endmodule

/* sim/tb_dense_grad.sv */
`timescale 1ns/100ps
`include "dense_consts.svh"

module tb_dense_grad;

  import fixed_pkg::*;
  import dense_shape_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int BLOCKS  = `DG_OUT_DIM / `DG_LANES;
  // first write after 5 cycles, then one word per cycle
  localparam int DONE_AT = 5 + `DG_WORDS - 1;

  logic clk;
  logic rst_n;
  logic run;
  logic done;
  sample_t [`DG_BATCH*`DG_HID_DIM-1:0] fwd_bus;
  sample_t [`DG_BATCH*`DG_OUT_DIM-1:0] bwd_bus;
  grad_addr_t host_raddr;
  grad_word_t host_rdata;
  logic       host_we;
  grad_addr_t host_waddr;
  grad_word_t host_wdata;

  // expected memory contents
  acc_t        model [`DG_WORDS][`DG_LANES];
  logic [31:0] lcg_state;
  int          err_count;
  int          check_count;
  int          test_count;

  dense_grad_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .d_forward  (fwd_bus),
    .d_backward (bwd_bus),
    .done       (done),
    .host_raddr (host_raddr),
    .host_rdata (host_rdata),
    .host_we    (host_we),
    .host_waddr (host_waddr),
    .host_wdata (host_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int grad_addr(int h, int c);
    return h * BLOCKS + c / `DG_LANES;
  endfunction

  // four-state compare, an unknown actual value never matches
  task automatic check_value(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    $display("test %s finished, %0d errors", name, err_count - errs_before);
  endtask

  task automatic write_word(input int addr, input grad_word_t word);
    @(negedge clk);
    host_we    = 1'b1;
    host_waddr = grad_addr_t'(addr);
    host_wdata = word;
    @(negedge clk);
    host_we    = 1'b0;
  endtask

  // data comes back one cycle after the address
  task automatic read_word(input int addr, output grad_word_t word);
    @(negedge clk);
    host_raddr = grad_addr_t'(addr);
    @(negedge clk);
    word = host_rdata;
  endtask

  task automatic clear_memory();
    for (int a = 0; a < `DG_WORDS; a++) begin
      write_word(a, '0);
      for (int l = 0; l < `DG_LANES; l++) begin
        model[a][l] = '0;
      end
    end
  endtask

  task automatic fill_random();
    logic [31:0] r;
    for (int i = 0; i < `DG_BATCH*`DG_HID_DIM; i++) begin
      r = next_rand();
      fwd_bus[i] = sample_t'(r[23:16]);
    end
    for (int i = 0; i < `DG_BATCH*`DG_OUT_DIM; i++) begin
      r = next_rand();
      bwd_bus[i] = sample_t'(r[23:16]);
    end
  endtask

  // batch sum of products added to the prior word with 24-bit wrap
  task automatic apply_batch();
    int sum;
    int a;
    for (int h = 0; h < `DG_HID_DIM; h++) begin
      for (int c = 0; c < `DG_OUT_DIM; c++) begin
        sum = 0;
        for (int n = 0; n < `DG_BATCH; n++) begin
          sum += int'(fwd_bus[n*`DG_HID_DIM + h]) * int'(bwd_bus[n*`DG_OUT_DIM + c]);
        end
        a = grad_addr(h, c);
        model[a][c % `DG_LANES] = model[a][c % `DG_LANES] + acc_t'(sum);
      end
    end
  endtask

  task automatic run_batch(input string name, input int hold, output int pulses);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    pulses = 0;
    @(negedge clk);
    run = 1'b1;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (done) begin
        pulses++;
        seen = 1'b1;
      end
    end
    if (!seen) begin
      err_count++;
      $display("%s: no done pulse within %0d cycles of raising run", name, TIMEOUT);
    end else begin
      check_value({name, " done latency"}, DONE_AT, cycles);
    end
    // the last write lands on the edge after done
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (done) begin
        pulses++;
      end
    end
    run = 1'b0;
  endtask

  task automatic compare_memory(input string name);
    grad_word_t word;
    for (int a = 0; a < `DG_WORDS; a++) begin
      read_word(a, word);
      for (int l = 0; l < `DG_LANES; l++) begin
        check_value($sformatf("%s addr %0d lane %0d", name, a, l), model[a][l], word[l]);
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_clear_readback();
    int errs;
    errs = err_count;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_value("clear_readback done idle", 0, done);
    end
    clear_memory();
    compare_memory("clear_readback");
    finish_test("clear_readback", errs);
  endtask

  task automatic test_unit_batch();
    int errs;
    int pulses;
    errs = err_count;
    clear_memory();
    for (int n = 0; n < `DG_BATCH; n++) begin
      for (int h = 0; h < `DG_HID_DIM; h++) begin
        fwd_bus[n*`DG_HID_DIM + h] = sample_t'(h + 1);
      end
      for (int c = 0; c < `DG_OUT_DIM; c++) begin
        bwd_bus[n*`DG_OUT_DIM + c] = sample_t'((c % 3) - 1);
      end
    end
    // same pair in every sample, so the sum is batch * product
    for (int h = 0; h < `DG_HID_DIM; h++) begin
      for (int c = 0; c < `DG_OUT_DIM; c++) begin
        model[grad_addr(h, c)][c % `DG_LANES] = acc_t'(`DG_BATCH * (h + 1) * ((c % 3) - 1));
      end
    end
    run_batch("unit_batch", 2, pulses);
    compare_memory("unit_batch");
    finish_test("unit_batch", errs);
  endtask

  task automatic test_random_batch();
    int errs;
    int pulses;
    errs = err_count;
    clear_memory();
    fill_random();
    apply_batch();
    run_batch("random_batch", 2, pulses);
    compare_memory("random_batch");
    finish_test("random_batch", errs);
  endtask

  task automatic test_accumulate();
    int errs;
    int pulses;
    grad_word_t word;
    errs = err_count;
    // start close to the positive limit so the sums wrap
    for (int a = 0; a < `DG_WORDS; a++) begin
      for (int l = 0; l < `DG_LANES; l++) begin
        word[l]     = acc_t'(24'h7fff00 + a * `DG_LANES + l);
        model[a][l] = word[l];
      end
      write_word(a, word);
    end
    fill_random();
    apply_batch();
    run_batch("accumulate first", 2, pulses);
    for (int i = 0; i < `DG_BATCH*`DG_HID_DIM; i++) begin
      fwd_bus[i] = sample_t'(127);
    end
    for (int i = 0; i < `DG_BATCH*`DG_OUT_DIM; i++) begin
      bwd_bus[i] = sample_t'(127);
    end
    apply_batch();
    run_batch("accumulate second", 2, pulses);
    compare_memory("accumulate");
    finish_test("accumulate", errs);
  endtask

  task automatic test_single_walk();
    int errs;
    int pulses;
    errs = err_count;
    clear_memory();
    fill_random();
    apply_batch();
    run_batch("single_walk", 40, pulses);
    check_value("single_walk done pulses", 1, pulses);
    compare_memory("single_walk");
    finish_test("single_walk", errs);
  endtask

  task automatic test_restart();
    int errs;
    int pulses;
    errs = err_count;
    fill_random();
    // partial walk dropped before done
    @(negedge clk);
    run = 1'b1;
    repeat (7) @(negedge clk);
    run = 1'b0;
    clear_memory();
    fill_random();
    apply_batch();
    run_batch("restart", 2, pulses);
    check_value("restart done pulses", 1, pulses);
    compare_memory("restart");
    finish_test("restart", errs);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    run         = 1'b0;
    fwd_bus     = '0;
    bwd_bus     = '0;
    host_raddr  = '0;
    host_we     = 1'b0;
    host_waddr  = '0;
    host_wdata  = '0;
    lcg_state   = 32'd52649;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_clear_readback();
    test_unit_batch();
    test_random_batch();
    test_accumulate();
    test_single_walk();
    test_restart();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
source/fixed_pkg.sv
source/dense_shape_pkg.sv
source/dense_dot.sv
source/dense_weight_grad.sv
source/grad_ram.sv
source/dense_grad_top.sv
sim/tb_dense_grad.sv
